//--- bench/msr_unit_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "msr_consts.svh"

module msr_unit_checker (
   input  logic                   clk,
   input  logic                   check_en,
   // DUT outputs
   input  logic [`MSR_DW-1:0]     rdata,
   input  logic                   rdata_valid,
   input  logic                   redirect,
   input  logic [`MSR_DW-1:0]     redirect_pc,
   input  logic [`MSR_PSR_DW-1:0] psr,
   input  logic [`MSR_PSR_DW-1:0] epsr,
   input  logic [`MSR_DW-1:0]     epc,
   // Expected bypass outputs for the current cycle
   input  logic [`MSR_PSR_DW-1:0] exp_psr,
   input  logic [`MSR_PSR_DW-1:0] exp_epsr,
   input  logic [`MSR_DW-1:0]     exp_epc,
   // Expected result stage outputs for the next cycle
   input  logic                   exp_rd_valid,
   input  logic [`MSR_DW-1:0]     exp_rdata,
   input  logic                   exp_redirect,
   input  logic [`MSR_DW-1:0]     exp_redirect_pc,
   output int                     err_count,
   output int                     check_count
);

   // Result stage expectations, one cycle behind the strobe
   logic               pend_rd_valid;
   logic [`MSR_DW-1:0] pend_rdata;
   logic               pend_redirect;
   logic [`MSR_DW-1:0] pend_redirect_pc;

   initial begin
      err_count        = 0;
      check_count      = 0;
      pend_rd_valid    = 1'b0;
      pend_rdata       = '0;
      pend_redirect    = 1'b0;
      pend_redirect_pc = '0;
   end

   task automatic compare(input string name, input logic [31:0] exp_v,
                          input logic [31:0] got_v);
      check_count = check_count + 1;
      if (got_v !== exp_v) begin
         err_count = err_count + 1;
         $display("Mismatch at %0t ns: %s expected 0x%08h got 0x%08h",
                  $time, name, exp_v, got_v);
      end
   endtask

   // Sampled on the rising edge, inputs settle from the falling edge
   always @(posedge clk) begin
      if (check_en) begin
         compare("psr", 32'(exp_psr), 32'(psr));
         compare("epsr", 32'(exp_epsr), 32'(epsr));
         compare("epc", exp_epc, epc);
         compare("rdata_valid", 32'(pend_rd_valid), 32'(rdata_valid));
         // Payloads only mean something with their strobe
         if (pend_rd_valid)
            compare("rdata", pend_rdata, rdata);
         compare("redirect", 32'(pend_redirect), 32'(redirect));
         if (pend_redirect)
            compare("redirect_pc", pend_redirect_pc, redirect_pc);
         pend_rd_valid    <= exp_rd_valid;
         pend_rdata       <= exp_rdata;
         pend_redirect    <= exp_redirect;
         pend_redirect_pc <= exp_redirect_pc;
      end else begin
         pend_rd_valid <= 1'b0;
         pend_redirect <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- bench/msr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "msr_consts.svh"

module msr_unit_tb;
   import msr_pkg::*;

   localparam logic [`MSR_DW-1:0] CORE_ID = 32'h0000_0003;
   localparam int RST_CYCLES = 8;
   localparam int MAX_ROWS   = 48;
   localparam int NUM_TESTS  = 6;
   localparam int MARGIN     = 20;
   localparam logic [31:0] SEED = 32'hc1be2088;

   // Implemented PSR bits and their reset value
   localparam logic [`MSR_PSR_DW-1:0] PSR_MASK =
      (`MSR_PSR_DW'(1) << `PSR_CC) | (`MSR_PSR_DW'(1) << `PSR_RM) |
      (`MSR_PSR_DW'(1) << `PSR_IRE) | (`MSR_PSR_DW'(1) << `PSR_IMME) |
      (`MSR_PSR_DW'(1) << `PSR_DMME);
   localparam logic [`MSR_PSR_DW-1:0] PSR_RST = PSR_MASK & ~(`MSR_PSR_DW'(1) << `PSR_CC);

   // CPUID as FEAT, REV, VER
   localparam logic [31:0] CPUID_EXP = (32'(`MSR_CPUID_FEAT) << 18) |
      (32'(`MSR_CPUID_REV) << 8) | 32'(`MSR_CPUID_VER);

   logic clk;
   logic rst;
   logic op_valid;
   msr_op_e op;
   msr_addr_e addr;
   logic [31:0] wdata;
   logic [31:0] pc;
   logic lsa_fault;
   logic [31:0] fault_addr;
   logic [31:0] rdata;
   logic rdata_valid;
   logic redirect;
   logic [31:0] redirect_pc;
   logic [`MSR_PSR_DW-1:0] psr;
   logic [`MSR_PSR_DW-1:0] epsr;
   logic [31:0] epc;

   // Expectations handed to the checker
   logic check_en;
   logic [`MSR_PSR_DW-1:0] exp_psr;
   logic [`MSR_PSR_DW-1:0] exp_epsr;
   logic [31:0] exp_epc;
   logic exp_rd_valid;
   logic [31:0] exp_rdata;
   logic exp_redirect;
   logic [31:0] exp_redirect_pc;
   int err_count;
   int check_count;

   // Stimulus table
   int        t_test   [MAX_ROWS];
   logic      t_valid  [MAX_ROWS];
   msr_op_e   t_op     [MAX_ROWS];
   msr_addr_e t_addr   [MAX_ROWS];
   logic [31:0] t_wdata [MAX_ROWS];
   logic [31:0] t_pc    [MAX_ROWS];
   logic      t_fault  [MAX_ROWS];
   logic [31:0] t_faddr [MAX_ROWS];
   int n_rows = 0;

   // Reference model state
   logic [`MSR_PSR_DW-1:0] m_psr;
   logic [`MSR_PSR_DW-1:0] m_epsr;
   logic [31:0] m_epc;
   logic [31:0] m_elsa;

   logic [31:0] lfsr_state;
   int cycle_cnt = 0;
   int cycle_limit = 1000;
   int test_err_base = 0;
   int tests_pass = 0;
   int tests_fail = 0;
   int row;

   msr_unit_top #(
      .CORE_ID (CORE_ID)
   ) UUT (
      .clk         (clk),
      .rst         (rst),
      .op_valid    (op_valid),
      .op          (op),
      .addr        (addr),
      .wdata       (wdata),
      .pc          (pc),
      .lsa_fault   (lsa_fault),
      .fault_addr  (fault_addr),
      .rdata       (rdata),
      .rdata_valid (rdata_valid),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .psr         (psr),
      .epsr        (epsr),
      .epc         (epc)
   );

   msr_unit_checker u_checker (
      .clk             (clk),
      .check_en        (check_en),
      .rdata           (rdata),
      .rdata_valid     (rdata_valid),
      .redirect        (redirect),
      .redirect_pc     (redirect_pc),
      .psr             (psr),
      .epsr            (epsr),
      .epc             (epc),
      .exp_psr         (exp_psr),
      .exp_epsr        (exp_epsr),
      .exp_epc         (exp_epc),
      .exp_rd_valid    (exp_rd_valid),
      .exp_rdata       (exp_rdata),
      .exp_redirect    (exp_redirect),
      .exp_redirect_pc (exp_redirect_pc),
      .err_count       (err_count),
      .check_count     (check_count)
   );

   always #10 clk = ~clk;

   // Run limit
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Test failures found");
         $finish;
      end
   end

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One step per bit taken
   task automatic lfsr_word(output logic [31:0] w);
      w = '0;
      for (int i = 0; i < 32; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         w = {w[30:0], lfsr_state[0]};
      end
   endtask

   function automatic string test_name(input int t);
      case (t)
         1: return "reset values and ID registers";
         2: return "EPSR EPC ELSA write and read";
         3: return "SETCC, PSR write, read-only writes";
         4: return "SYSCALL entry";
         5: return "load/store fault drops op";
         6: return "ERET return and redirect";
         default: return "unknown";
      endcase
   endfunction

   task automatic add_row(input int test, input logic valid, input msr_op_e o,
                          input msr_addr_e a, input logic [31:0] p, input logic flt,
                          input logic [31:0] fa, input logic [31:0] wd);
      t_test[n_rows]  = test;
      t_valid[n_rows] = valid;
      t_op[n_rows]    = o;
      t_addr[n_rows]  = a;
      t_wdata[n_rows] = wd;
      t_pc[n_rows]    = p;
      t_fault[n_rows] = flt;
      t_faddr[n_rows] = fa;
      n_rows = n_rows + 1;
   endtask

   // MTSR wdata is replaced from the LFSR in the loop
   task automatic build_table();
      add_row(1, 1'b1, MSR_MFSR, SR_PSR, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(1, 1'b1, MSR_MFSR, SR_CPUID, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(1, 1'b1, MSR_MFSR, SR_COREID, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(1, 1'b1, MSR_MFSR, SR_EPC, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(2, 1'b1, MSR_MTSR, SR_EPSR, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(2, 1'b1, MSR_MFSR, SR_EPSR, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(2, 1'b1, MSR_MTSR, SR_EPC, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(2, 1'b1, MSR_MFSR, SR_EPC, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(2, 1'b1, MSR_MTSR, SR_ELSA, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(2, 1'b1, MSR_MFSR, SR_ELSA, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(3, 1'b1, MSR_SETCC, SR_PSR, 32'h0, 1'b0, 32'h0, 32'hffff_ffff);
      add_row(3, 1'b1, MSR_MFSR, SR_PSR, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(3, 1'b1, MSR_SETCC, SR_PSR, 32'h0, 1'b0, 32'h0, 32'h0000_0000);
      add_row(3, 1'b1, MSR_MTSR, SR_PSR, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(3, 1'b1, MSR_MFSR, SR_PSR, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(3, 1'b1, MSR_MTSR, SR_CPUID, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(3, 1'b1, MSR_MTSR, SR_COREID, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(3, 1'b1, MSR_MFSR, SR_CPUID, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(3, 1'b1, MSR_MFSR, SR_COREID, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(3, 1'b1, MSR_MFSR, SR_PSR, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(4, 1'b1, MSR_SETCC, SR_PSR, 32'h0, 1'b0, 32'h0, 32'h0000_0001);
      add_row(4, 1'b1, MSR_SYSCALL, SR_PSR, 32'h0000_1000, 1'b0, 32'h0, 32'h0);
      add_row(4, 1'b1, MSR_MFSR, SR_PSR, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(4, 1'b1, MSR_MFSR, SR_EPSR, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(4, 1'b1, MSR_MFSR, SR_EPC, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(5, 1'b1, MSR_MTSR, SR_EPC, 32'h0000_2004, 1'b1, 32'hdead_beef, 32'h0);
      add_row(5, 1'b1, MSR_MFSR, SR_ELSA, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(5, 1'b1, MSR_MFSR, SR_EPC, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(5, 1'b1, MSR_MFSR, SR_ELSA, 32'h0000_2010, 1'b1, 32'h1234_5678, 32'h0);
      add_row(5, 1'b1, MSR_MFSR, SR_ELSA, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(5, 1'b1, MSR_MFSR, SR_EPSR, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(6, 1'b1, MSR_MTSR, SR_EPSR, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(6, 1'b1, MSR_MTSR, SR_EPC, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(6, 1'b1, MSR_ERET, SR_PSR, 32'h0000_3000, 1'b0, 32'h0, 32'h0);
      add_row(6, 1'b1, MSR_MFSR, SR_PSR, 32'h0, 1'b0, 32'h0, 32'h0);
      add_row(6, 1'b1, MSR_ERET, SR_PSR, 32'h0000_3004, 1'b0, 32'h0, 32'h0);
      add_row(6, 1'b1, MSR_MFSR, SR_EPC, 32'h0, 1'b0, 32'h0, 32'h0);
   endtask

   function automatic logic [31:0] read_reg(input msr_addr_e a);
      case (a)
         SR_PSR:    return 32'(m_psr);
         SR_CPUID:  return CPUID_EXP;
         SR_EPSR:   return 32'(m_epsr);
         SR_EPC:    return m_epc;
         SR_ELSA:   return m_elsa;
         SR_COREID: return CORE_ID;
         default:   return 32'h0;
      endcase
   endfunction

   // Root mode on, interrupts and MMUs off, CC untouched
   function automatic logic [`MSR_PSR_DW-1:0] enter_psr(input logic [`MSR_PSR_DW-1:0] s);
      logic [`MSR_PSR_DW-1:0] r;
      r = s;
      r[`PSR_RM]   = 1'b1;
      r[`PSR_IRE]  = 1'b0;
      r[`PSR_IMME] = 1'b0;
      r[`PSR_DMME] = 1'b0;
      return r;
   endfunction

   // Expected outputs for one cycle, then the state after its edge
   task automatic model_step(input logic valid, input msr_op_e o, input msr_addr_e a,
                             input logic [31:0] wd, input logic [31:0] p,
                             input logic flt, input logic [31:0] fa);
      logic [`MSR_PSR_DW-1:0] psr_n;
      logic [`MSR_PSR_DW-1:0] epsr_n;
      logic [31:0] epc_n;
      logic [31:0] elsa_n;
      exp_psr         = m_psr;
      exp_epsr        = m_epsr;
      exp_epc         = m_epc;
      exp_rd_valid    = 1'b0;
      exp_rdata       = 32'h0;
      exp_redirect    = 1'b0;
      exp_redirect_pc = 32'h0;
      psr_n  = m_psr;
      epsr_n = m_epsr;
      epc_n  = m_epc;
      elsa_n = m_elsa;
      if (flt) begin
         // Fault wins and the op is dropped
         epsr_n = m_psr;
         epc_n  = p;
         elsa_n = fa;
         psr_n  = enter_psr(m_psr);
      end else if (valid) begin
         case (o)
            MSR_MFSR: begin
               exp_rd_valid = 1'b1;
               exp_rdata    = read_reg(a);
            end
            MSR_MTSR: begin
               case (a)
                  SR_PSR: begin
                     exp_psr = wd[`MSR_PSR_DW-1:0] & PSR_MASK;
                     psr_n   = exp_psr;
                  end
                  SR_EPSR: begin
                     exp_epsr = wd[`MSR_PSR_DW-1:0];
                     epsr_n   = exp_epsr;
                  end
                  SR_EPC: begin
                     exp_epc = wd;
                     epc_n   = wd;
                  end
                  SR_ELSA: elsa_n = wd;
                  default: ;
               endcase
            end
            MSR_SETCC: begin
               exp_psr[`PSR_CC] = wd[0];
               psr_n = exp_psr;
            end
            MSR_SYSCALL: begin
               epsr_n = m_psr;
               epc_n  = p;
               psr_n  = enter_psr(m_psr);
            end
            MSR_ERET: begin
               psr_n           = m_epsr & PSR_MASK;
               exp_redirect    = 1'b1;
               exp_redirect_pc = m_epc;
            end
            default: ;
         endcase
      end
      m_psr  = psr_n;
      m_epsr = epsr_n;
      m_epc  = epc_n;
      m_elsa = elsa_n;
   endtask

   task automatic drive_step(input logic valid, input msr_op_e o, input msr_addr_e a,
                             input logic [31:0] wd, input logic [31:0] p,
                             input logic flt, input logic [31:0] fa);
      @(negedge clk);
      check_en   = 1'b1;
      op_valid   = valid;
      op         = o;
      addr       = a;
      wdata      = wd;
      pc         = p;
      lsa_fault  = flt;
      fault_addr = fa;
      model_step(valid, o, a, wd, p, flt, fa);
   endtask

   task automatic report_test(input int t);
      int errs;
      errs = err_count - test_err_base;
      if (errs == 0) begin
         $display("Test %0d %s: PASS", t, test_name(t));
         tests_pass = tests_pass + 1;
      end else begin
         $display("Test %0d %s: FAIL with %0d mismatches", t, test_name(t), errs);
         tests_fail = tests_fail + 1;
      end
      test_err_base = err_count;
   endtask

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      op_valid   = 1'b0;
      op         = MSR_NOP;
      addr       = SR_PSR;
      wdata      = 32'h0;
      pc         = 32'h0;
      lsa_fault  = 1'b0;
      fault_addr = 32'h0;
      check_en   = 1'b0;
      exp_psr         = PSR_RST;
      exp_epsr        = '0;
      exp_epc         = 32'h0;
      exp_rd_valid    = 1'b0;
      exp_rdata       = 32'h0;
      exp_redirect    = 1'b0;
      exp_redirect_pc = 32'h0;
      lfsr_state = SEED;
      m_psr  = PSR_RST;
      m_epsr = '0;
      m_epc  = 32'h0;
      m_elsa = 32'h0;
      build_table();
      // Rows, two idle cycles per test, reset and margin
      cycle_limit = n_rows + 2 * NUM_TESTS + RST_CYCLES + MARGIN;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (row = 0; row < n_rows; row++) begin
         if (t_op[row] == MSR_MTSR)
            lfsr_word(t_wdata[row]);
         drive_step(t_valid[row], t_op[row], t_addr[row], t_wdata[row], t_pc[row],
                    t_fault[row], t_faddr[row]);
         // Idle cycle drains the result stage before the test is scored
         if (row == n_rows - 1 || t_test[row + 1] != t_test[row]) begin
            drive_step(1'b0, MSR_NOP, SR_PSR, 32'h0, 32'h0, 1'b0, 32'h0);
            @(negedge clk);
            report_test(t_test[row]);
         end
      end
      $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d mismatches",
               tests_pass, tests_fail, check_count, err_count);
      if (tests_fail == 0 && err_count == 0 && check_count > 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- common/msr_consts.svh
`ifndef MSR_CONSTS_SVH
`define MSR_CONSTS_SVH

// Datapath width of the core
`define MSR_DW 32

// Width of PSR and EPSR
`define MSR_PSR_DW 10

// PSR bit positions
// Condition flag, set by SETCC or compare ops
`define PSR_CC 0

// Root mode
`define PSR_RM 4

// Interrupt enable
`define PSR_IRE 5

// Instruction MMU enable
`define PSR_IMME 6

// Data MMU enable
`define PSR_DMME 7

// bits 1..3 and 8..9 are reserved and read as zero

// CPUID fields
// Packed as FEAT, REV, VER from MSB down to bit 0
// Version, bits 7:0
`define MSR_CPUID_VER 8'd1

// Revision, bits 17:8
`define MSR_CPUID_REV 10'd0

// Feature mask, bits 25:18
// bit 0 IMMU, bit 1 DMMU, bit 2 ICACHE, bit 3 DCACHE
// bit 4 debug, bit 5 FPU, bit 6 IRQC, bit 7 TSC
`define MSR_CPUID_FEAT 8'h01

// Field widths inside CPUID
`define MSR_CPUID_LOW_W 26

`endif

//--- common/msr_pkg.sv
`default_nettype none

package msr_pkg;

   // MSR operation codes
   // One op per cycle, qualified by op_valid
   typedef enum logic [2:0] {
      // No operation
      MSR_NOP     = 3'd0,
      // Move from MSR into rdata
      MSR_MFSR    = 3'd1,
      // Move wdata into MSR
      MSR_MTSR    = 3'd2,
      // Write condition flag from wdata bit 0
      MSR_SETCC   = 3'd3,
      // Software exception entry
      MSR_SYSCALL = 3'd4,
      // Return from exception
      MSR_ERET    = 3'd5
   } msr_op_e;

   // MSR addresses
   // Codes 6 and 7 are unused and read as zero
   typedef enum logic [2:0] {
      // Processor status
      SR_PSR    = 3'd0,
      // CPU identification, read-only
      SR_CPUID  = 3'd1,
      // PSR saved on exception entry
      SR_EPSR   = 3'd2,
      // PC saved on exception entry
      SR_EPC    = 3'd3,
      // Faulting load/store address
      SR_ELSA   = 3'd4,
      // Core index, read-only
      SR_COREID = 3'd5
   } msr_addr_e;

endpackage

`default_nettype wire

//--- compile.f
+incdir+common
common/msr_pkg.sv
src/msr_decode.sv
msr/msr_exc_ctrl.sv
msr/msr_psr_file.sv
src/msr_read_mux.sv
src/msr_unit_top.sv
bench/msr_unit_checker.sv
bench/msr_unit_tb.sv

//--- msr/msr_exc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "msr_consts.svh"

module msr_exc_ctrl (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   syscall,
   input  logic                   eret,
   input  logic                   fault,
   input  logic [`MSR_DW-1:0]     fault_addr,
   input  logic [`MSR_DW-1:0]     pc,
   input  logic [`MSR_PSR_DW-1:0] psr_cur,
   input  logic [`MSR_PSR_DW-1:0] epsr_cur,
   output logic                   exc_enter,
   output logic                   exc_return,
   output logic [`MSR_PSR_DW-1:0] epsr_save,
   output logic [`MSR_DW-1:0]     epc_save,
   output logic [`MSR_DW-1:0]     elsa_save,
   output logic                   elsa_save_we,
   output logic [`MSR_PSR_DW-1:0] psr_restore
);

   // Implemented PSR bits
   // The rest restore as zero
   localparam logic [`MSR_PSR_DW-1:0] PSR_MASK =
      (`MSR_PSR_DW'(1) << `PSR_CC)   |
      (`MSR_PSR_DW'(1) << `PSR_RM)   |
      (`MSR_PSR_DW'(1) << `PSR_IRE)  |
      (`MSR_PSR_DW'(1) << `PSR_IMME) |
      (`MSR_PSR_DW'(1) << `PSR_DMME);

   // Exception cause
   // Fault wins over any op in the same cycle
   logic cause_fault;
   logic cause_sys;

   assign cause_fault = fault;
   assign cause_sys   = syscall & ~fault;

   // Entry on either cause
   assign exc_enter  = cause_fault | cause_sys;

   // Return requested by ERET
   assign exc_return = eret;

   // Values saved on entry
   assign epsr_save = psr_cur & PSR_MASK;
   assign epc_save  = pc;

   // ELSA only tracks load/store faults
   assign elsa_save    = fault_addr;
   assign elsa_save_we = cause_fault;

   // PSR reloaded from EPSR on return
   assign psr_restore = epsr_cur & PSR_MASK;

   // Entry and return are exclusive
   a_enter_return_excl: assert property (@(posedge clk) disable iff (rst)
      !(exc_enter && exc_return))
      else $error("exception entry and return in the same cycle");

endmodule

`default_nettype wire

//--- msr/msr_psr_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "msr_consts.svh"

module msr_psr_file (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   psr_we,
   input  logic                   cc_we,
   input  logic                   cc_nxt,
   input  logic                   epsr_we,
   input  logic                   epc_we,
   input  logic                   elsa_we,
   input  logic [`MSR_DW-1:0]     wr_data,
   input  logic                   exc_enter,
   input  logic                   exc_return,
   input  logic [`MSR_PSR_DW-1:0] epsr_save,
   input  logic [`MSR_DW-1:0]     epc_save,
   input  logic [`MSR_DW-1:0]     elsa_save,
   input  logic                   elsa_save_we,
   input  logic [`MSR_PSR_DW-1:0] psr_restore,
   output logic [`MSR_PSR_DW-1:0] psr,
   output logic [`MSR_PSR_DW-1:0] epsr,
   output logic [`MSR_DW-1:0]     epc,
   output logic [`MSR_DW-1:0]     elsa
);

   // Registered PSR flags
   logic cc_r;
   logic rm_r;
   logic ire_r;
   logic imme_r;
   logic dmme_r;

   // Exception save registers
   logic [`MSR_PSR_DW-1:0] epsr_r;
   logic [`MSR_DW-1:0]     epc_r;
   logic [`MSR_DW-1:0]     elsa_r;

   // Bypassed flag values
   logic cc_byp;
   logic rm_byp;
   logic ire_byp;
   logic imme_byp;
   logic dmme_byp;

   // Software writes only count outside exception entry and return
   logic sw_en;

   assign sw_en = ~exc_enter & ~exc_return;

   // Flag bypass, a full PSR write beats SETCC
   assign cc_byp   = (sw_en & psr_we) ? wr_data[`PSR_CC] :
                     (sw_en & cc_we)  ? cc_nxt : cc_r;
   assign rm_byp   = (sw_en & psr_we) ? wr_data[`PSR_RM]   : rm_r;
   assign ire_byp  = (sw_en & psr_we) ? wr_data[`PSR_IRE]  : ire_r;
   assign imme_byp = (sw_en & psr_we) ? wr_data[`PSR_IMME] : imme_r;
   assign dmme_byp = (sw_en & psr_we) ? wr_data[`PSR_DMME] : dmme_r;

   // Save register bypass
   assign epsr = (sw_en & epsr_we) ? wr_data[`MSR_PSR_DW-1:0] : epsr_r;
   assign epc  = (sw_en & epc_we)  ? wr_data : epc_r;
   assign elsa = (elsa_we & ~elsa_save_we) ? wr_data : elsa_r;

   // Pack flags, reserved bits read zero
   always_comb begin
      psr            = '0;
      psr[`PSR_CC]   = cc_byp;
      psr[`PSR_RM]   = rm_byp;
      psr[`PSR_IRE]  = ire_byp;
      psr[`PSR_IMME] = imme_byp;
      psr[`PSR_DMME] = dmme_byp;
   end

   // PSR flags
   // Entry and return only show after the edge
   always_ff @(posedge clk) begin
      if (rst) begin
         cc_r   <= 1'b0;
         rm_r   <= 1'b1;
         ire_r  <= 1'b1;
         imme_r <= 1'b1;
         dmme_r <= 1'b1;
      end else if (exc_enter) begin
         // Root mode, interrupts and MMUs off, CC kept
         rm_r   <= 1'b1;
         ire_r  <= 1'b0;
         imme_r <= 1'b0;
         dmme_r <= 1'b0;
      end else if (exc_return) begin
         cc_r   <= psr_restore[`PSR_CC];
         rm_r   <= psr_restore[`PSR_RM];
         ire_r  <= psr_restore[`PSR_IRE];
         imme_r <= psr_restore[`PSR_IMME];
         dmme_r <= psr_restore[`PSR_DMME];
      end else begin
         cc_r   <= cc_byp;
         rm_r   <= rm_byp;
         ire_r  <= ire_byp;
         imme_r <= imme_byp;
         dmme_r <= dmme_byp;
      end
   end

   // EPSR, EPC and ELSA
   // Entry save overrides a software write
   always_ff @(posedge clk) begin
      if (rst) begin
         epsr_r <= '0;
         epc_r  <= '0;
         elsa_r <= '0;
      end else begin
         epsr_r <= exc_enter ? epsr_save : epsr;
         epc_r  <= exc_enter ? epc_save : epc;
         elsa_r <= elsa_save_we ? elsa_save : elsa;
      end
   end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the MSR unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module msr_unit_tb -f compile.f -o msr_unit_sim

./obj_dir/msr_unit_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
   echo "Simulation reported failures"
   exit 1
fi

if ! grep -q "All tests passed!" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi

echo "Simulation passed"

//--- src/msr_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "msr_consts.svh"

module msr_decode (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 op_valid,
   input  msr_pkg::msr_op_e     op,
   input  msr_pkg::msr_addr_e   addr,
   input  logic [`MSR_DW-1:0]   wdata,
   input  logic                 fault,
   output logic                 psr_we,
   output logic                 epsr_we,
   output logic                 epc_we,
   output logic                 elsa_we,
   output logic                 cc_we,
   output logic                 cc_nxt,
   output logic [`MSR_DW-1:0]   wr_data,
   output logic                 rd_req,
   output msr_pkg::msr_addr_e   rd_addr,
   output logic                 syscall,
   output logic                 eret
);
   import msr_pkg::*;

   // Op accepted this cycle
   // A fault in the same cycle drops the op
   logic act;

   assign act = op_valid & ~fault;

   always_comb begin
      // Defaults, everything idle
      psr_we  = 1'b0;
      epsr_we = 1'b0;
      epc_we  = 1'b0;
      elsa_we = 1'b0;
      cc_we   = 1'b0;
      cc_nxt  = 1'b0;
      wr_data = '0;
      rd_req  = 1'b0;
      rd_addr = SR_PSR;
      syscall = 1'b0;
      eret    = 1'b0;
      if (act) begin
         case (op)
            MSR_MFSR: begin
               rd_req  = 1'b1;
               rd_addr = addr;
            end
            MSR_MTSR: begin
               wr_data = wdata;
               case (addr)
                  SR_PSR:  psr_we  = 1'b1;
                  SR_EPSR: epsr_we = 1'b1;
                  SR_EPC:  epc_we  = 1'b1;
                  SR_ELSA: elsa_we = 1'b1;
                  // CPUID and COREID are constant, write dropped
                  default: ;
               endcase
            end
            MSR_SETCC: begin
               cc_we  = 1'b1;
               cc_nxt = wdata[0];
            end
            MSR_SYSCALL: syscall = 1'b1;
            MSR_ERET:    eret    = 1'b1;
            default: ;
         endcase
      end
   end

   // Read-only registers never see a write enable
   a_ro_no_we: assert property (@(posedge clk) disable iff (rst)
      (op_valid && op == MSR_MTSR && (addr == SR_CPUID || addr == SR_COREID))
      |-> !(psr_we || epsr_we || epc_we || elsa_we || cc_we))
      else $error("write enable raised for read-only MSR");

endmodule

`default_nettype wire

//--- src/msr_read_mux.sv
`timescale 1ns/1ps
`default_nettype none
`include "msr_consts.svh"

module msr_read_mux #(
   parameter logic [`MSR_DW-1:0] CORE_ID = '0
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   rd_req,
   input  msr_pkg::msr_addr_e     rd_addr,
   input  logic                   eret,
   input  logic [`MSR_PSR_DW-1:0] psr,
   input  logic [`MSR_PSR_DW-1:0] epsr,
   input  logic [`MSR_DW-1:0]     epc,
   input  logic [`MSR_DW-1:0]     elsa,
   output logic [`MSR_DW-1:0]     rdata,
   output logic                   rdata_valid,
   output logic                   redirect,
   output logic [`MSR_DW-1:0]     redirect_pc
);
   import msr_pkg::*;

   // CPUID word, upper bits unused
   localparam logic [`MSR_DW-1:0] CPUID = {
      {(`MSR_DW - `MSR_CPUID_LOW_W){1'b0}},
      `MSR_CPUID_FEAT, `MSR_CPUID_REV, `MSR_CPUID_VER};

   logic [`MSR_DW-1:0] rd_sel;

   // Register select, PSR-sized values zero extended
   always_comb begin
      case (rd_addr)
         SR_PSR:    rd_sel = {{(`MSR_DW - `MSR_PSR_DW){1'b0}}, psr};
         SR_CPUID:  rd_sel = CPUID;
         SR_EPSR:   rd_sel = {{(`MSR_DW - `MSR_PSR_DW){1'b0}}, epsr};
         SR_EPC:    rd_sel = epc;
         SR_ELSA:   rd_sel = elsa;
         SR_COREID: rd_sel = CORE_ID;
         default:   rd_sel = '0;
      endcase
   end

   // Valid and redirect strobes
   always_ff @(posedge clk) begin
      if (rst) begin
         rdata_valid <= 1'b0;
         redirect    <= 1'b0;
      end else begin
         rdata_valid <= rd_req;
         redirect    <= eret;
      end
   end

   // Payload, held between strobes
   // redirect_pc takes EPC as seen in the ERET cycle
   always_ff @(posedge clk) begin
      if (rd_req)
         rdata <= rd_sel;
      if (eret)
         redirect_pc <= epc;
   end

endmodule

`default_nettype wire

//--- src/msr_unit_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "msr_consts.svh"

module msr_unit_top #(
   parameter logic [`MSR_DW-1:0] CORE_ID = '0
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   op_valid,
   input  msr_pkg::msr_op_e       op,
   input  msr_pkg::msr_addr_e     addr,
   input  logic [`MSR_DW-1:0]     wdata,
   input  logic [`MSR_DW-1:0]     pc,
   input  logic                   lsa_fault,
   input  logic [`MSR_DW-1:0]     fault_addr,
   output logic [`MSR_DW-1:0]     rdata,
   output logic                   rdata_valid,
   output logic                   redirect,
   output logic [`MSR_DW-1:0]     redirect_pc,
   output logic [`MSR_PSR_DW-1:0] psr,
   output logic [`MSR_PSR_DW-1:0] epsr,
   output logic [`MSR_DW-1:0]     epc
);
   import msr_pkg::*;

   // Decode to register file
   logic               psr_we;
   logic               epsr_we;
   logic               epc_we;
   logic               elsa_we;
   logic               cc_we;
   logic               cc_nxt;
   logic [`MSR_DW-1:0] wr_data;

   // Decode to read mux and exception control
   logic      rd_req;
   msr_addr_e rd_addr;
   logic      syscall;
   logic      eret;

   // Exception control to register file
   logic                   exc_enter;
   logic                   exc_return;
   logic [`MSR_PSR_DW-1:0] epsr_save;
   logic [`MSR_DW-1:0]     epc_save;
   logic [`MSR_DW-1:0]     elsa_save;
   logic                   elsa_save_we;
   logic [`MSR_PSR_DW-1:0] psr_restore;

   // only read back through MFSR
   logic [`MSR_DW-1:0] elsa;

   msr_decode u_decode (
      .clk      (clk),
      .rst      (rst),
      .op_valid (op_valid),
      .op       (op),
      .addr     (addr),
      .wdata    (wdata),
      .fault    (lsa_fault),
      .psr_we   (psr_we),
      .epsr_we  (epsr_we),
      .epc_we   (epc_we),
      .elsa_we  (elsa_we),
      .cc_we    (cc_we),
      .cc_nxt   (cc_nxt),
      .wr_data  (wr_data),
      .rd_req   (rd_req),
      .rd_addr  (rd_addr),
      .syscall  (syscall),
      .eret     (eret)
   );

   msr_exc_ctrl u_exc_ctrl (
      .clk          (clk),
      .rst          (rst),
      .syscall      (syscall),
      .eret         (eret),
      .fault        (lsa_fault),
      .fault_addr   (fault_addr),
      .pc           (pc),
      .psr_cur      (psr),
      .epsr_cur     (epsr),
      .exc_enter    (exc_enter),
      .exc_return   (exc_return),
      .epsr_save    (epsr_save),
      .epc_save     (epc_save),
      .elsa_save    (elsa_save),
      .elsa_save_we (elsa_save_we),
      .psr_restore  (psr_restore)
   );

   msr_psr_file u_psr_file (
      .clk          (clk),
      .rst          (rst),
      .psr_we       (psr_we),
      .cc_we        (cc_we),
      .cc_nxt       (cc_nxt),
      .epsr_we      (epsr_we),
      .epc_we       (epc_we),
      .elsa_we      (elsa_we),
      .wr_data      (wr_data),
      .exc_enter    (exc_enter),
      .exc_return   (exc_return),
      .epsr_save    (epsr_save),
      .epc_save     (epc_save),
      .elsa_save    (elsa_save),
      .elsa_save_we (elsa_save_we),
      .psr_restore  (psr_restore),
      .psr          (psr),
      .epsr         (epsr),
      .epc          (epc),
      .elsa         (elsa)
   );

   msr_read_mux #(
      .CORE_ID (CORE_ID)
   ) u_read_mux (
      .clk         (clk),
      .rst         (rst),
      .rd_req      (rd_req),
      .rd_addr     (rd_addr),
      .eret        (eret),
      .psr         (psr),
      .epsr        (epsr),
      .epc         (epc),
      .elsa        (elsa),
      .rdata       (rdata),
      .rdata_valid (rdata_valid),
      .redirect    (redirect),
      .redirect_pc (redirect_pc)
   );

endmodule

`default_nettype wire
